// ==== filelist.f ====
source/depar_axis_pkg.sv
source/depar_action_pkg.sv
source/action_table.sv
source/field_extractor.sv
source/ctrl_table_writer.sv
source/pkt_rewriter.sv
source/deparser_top.sv
sim/deparser_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= deparser_tb
SRCS      ?= filelist.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(SRCS) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF '** PASS **' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== sim/deparser_tb.sv ====
`timescale 1ns/10ps

module deparser_tb;
	import depar_axis_pkg::*;
	import depar_action_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int NUM_TESTS = 10;

	typedef struct {
		string                   name;
		bit                      has_ctrl;
		logic [2:0]              mod_id;
		logic [TABLE_ADDR_W-1:0] addr;
		table_entry_t            acts;
		int                      len;       // packet length in beats
		bit                      discard;
		logic [11:0]             vlan;
		bit                      bp;        // random out_ready
		int                      exp_beats;
	} test_t;

	logic              clk;
	logic              aresetn;
	axis_beat_t        pkt_in;
	logic              pkt_empty;
	logic              pkt_rd_en;
	logic [PHV_W-1:0]  phv;
	logic              phv_empty;
	logic              phv_rd_en;
	axis_beat_t        depar_out;
	logic              out_valid;
	logic              out_ready;
	ctrl_beat_u        ctrl_beat;
	logic              ctrl_last;
	logic              ctrl_valid;

	test_t             tests [NUM_TESTS];
	table_entry_t      model_tbl [TABLE_DEPTH];
	axis_beat_t        pkt_q [$];
	logic [PHV_W-1:0]  phv_q [$];
	axis_beat_t        in_beats [$];
	axis_beat_t        exp_q [$];
	axis_beat_t        got [$];
	logic [31:0]       lfsr = 32'd79336;
	bit                cur_bp;
	int                test_errs;
	int                pass_cnt;
	int                fail_cnt;

	deparser_top uut (
		.clk        (clk),
		.aresetn    (aresetn),
		.pkt_in     (pkt_in),
		.pkt_empty  (pkt_empty),
		.pkt_rd_en  (pkt_rd_en),
		.phv        (phv),
		.phv_empty  (phv_empty),
		.phv_rd_en  (phv_rd_en),
		.depar_out  (depar_out),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.ctrl_beat  (ctrl_beat),
		.ctrl_last  (ctrl_last),
		.ctrl_valid (ctrl_valid)
	);

	always #(CLK_PERIOD/2) clk = ~clk;

	// taps 32 22 2 1
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
		lfsr = {lfsr[30:0], fb};
		return fb;
	endfunction

	function automatic logic [PHV_W-1:0] rand_bits(int n);
		logic [PHV_W-1:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v[i] = lfsr_bit();
		return v;
	endfunction

	function automatic logic [255:0] byte_swap(logic [255:0] v);
		logic [255:0] s;
		for (int i = 0; i < 32; i++)
			s[i*8 +: 8] = v[(31-i)*8 +: 8];
		return s;
	endfunction

	function automatic depar_action_t make_action(logic v, cont_type_t t, logic [2:0] idx,
			logic [5:0] off);
		depar_action_t a;
		a = '0;
		a.valid = v;
		a.ctype = t;
		a.idx = idx;
		a.offset = off;
		return a;
	endfunction

	task automatic load_tests();
		table_entry_t row_a;
		table_entry_t row_b;
		table_entry_t row_c;
		table_entry_t row_none;
		row_a = {make_action(1'b1, B2, 3'd1, 6'd2), make_action(1'b1, B4, 3'd0, 6'd10),
			make_action(1'b1, B6, 3'd7, 6'd20), make_action(1'b1, B2, 3'd5, 6'd34),
			make_action(1'b1, B6, 3'd3, 6'd50)};
		row_b = {make_action(1'b1, B6, 3'd0, 6'd0), make_action(1'b1, B4, 3'd2, 6'd40),
			make_action(1'b1, B2, 3'd3, 6'd16), make_action(1'b1, B6, 3'd5, 6'd26),
			make_action(1'b1, B4, 3'd7, 6'd58)};
		// overlapping fields, plus an invalid action sitting on bytes 0-1
		row_c = {make_action(1'b1, B6, 3'd2, 6'd8), make_action(1'b1, B4, 3'd6, 6'd10),
			make_action(1'b1, B2, 3'd0, 6'd12), make_action(1'b0, B2, 3'd0, 6'd0),
			make_action(1'b1, B6, 3'd4, 6'd58)};
		row_none = '0;
		tests[0] = '{"ctrl_write_rewrite", 1'b1, 3'd5, 5'd3, row_a, 2, 1'b0, 12'h03a, 1'b0, 2};
		tests[1] = '{"foreign_module_id", 1'b1, 3'd3, 5'd3, row_b, 2, 1'b0, 12'he3a, 1'b0, 2};
		tests[2] = '{"discard_packet", 1'b0, 3'd0, 5'd0, row_none, 3, 1'b1, 12'h03a, 1'b0, 0};
		tests[3] = '{"after_discard", 1'b0, 3'd0, 5'd0, row_none, 2, 1'b0, 12'h030, 1'b0, 2};
		tests[4] = '{"four_beat_tail", 1'b0, 3'd0, 5'd0, row_none, 4, 1'b0, 12'h03a, 1'b0, 4};
		tests[5] = '{"single_beat", 1'b0, 3'd0, 5'd0, row_none, 1, 1'b0, 12'h030, 1'b0, 1};
		tests[6] = '{"overlap_write", 1'b1, 3'd5, 5'd9, row_c, 2, 1'b0, 12'h09c, 1'b0, 2};
		tests[7] = '{"backpressure_short", 1'b0, 3'd0, 5'd0, row_none, 3, 1'b0, 12'h09c, 1'b1, 3};
		tests[8] = '{"backpressure_long", 1'b0, 3'd0, 5'd0, row_none, 5, 1'b0, 12'h03a, 1'b1, 5};
		tests[9] = '{"discard_one_beat", 1'b0, 3'd0, 5'd0, row_none, 1, 1'b1, 12'h030, 1'b0, 0};
	endtask

	task automatic update_heads();
		pkt_empty = (pkt_q.size() == 0);
		phv_empty = (phv_q.size() == 0);
		pkt_in = '0;
		phv = '0;
		if (!pkt_empty)
			pkt_in = pkt_q[0];
		if (!phv_empty)
			phv = phv_q[0];
	endtask

	// called at a falling edge, returns at the next one
	task automatic cycle();
		logic pop_pkt;
		logic pop_phv;
		#(CLK_PERIOD/2 - 1);  // settled, just before the rising edge
		pop_pkt = pkt_rd_en;
		pop_phv = phv_rd_en;
		if (out_valid && out_ready)
			got.push_back(depar_out);
		@(negedge clk);
		if (pop_pkt && pkt_q.size() == 0) begin
			$display("DUT read the packet FIFO while it was empty");
			test_errs++;
		end else if (pop_pkt) begin
			void'(pkt_q.pop_front());
		end
		if (pop_phv && phv_q.size() == 0) begin
			$display("DUT read the PHV FIFO while it was empty");
			test_errs++;
		end else if (pop_phv) begin
			void'(phv_q.pop_front());
		end
		out_ready = cur_bp ? lfsr_bit() : 1'b1;
		update_heads();
	endtask

	task automatic send_ctrl(logic [2:0] mod, logic [TABLE_ADDR_W-1:0] addr, table_entry_t acts);
		logic [PHV_W-1:0] r;
		logic [255:0]     hdr;
		logic [255:0]     rev;
		r = rand_bits(256);
		ctrl_valid = 1'b1;
		ctrl_last = 1'b0;
		ctrl_beat = r[255:0];
		cycle();
		hdr = '0;
		hdr[119:112] = {5'b0, mod};
		hdr[135:128] = {3'b0, addr};
		ctrl_beat = hdr;
		cycle();
		r = rand_bits(256);
		rev = {acts, r[175:0]};  // entry is the top 80 bits once reversed
		ctrl_beat = byte_swap(rev);
		cycle();
		r = rand_bits(256);
		ctrl_beat = r[255:0];
		ctrl_last = 1'b1;
		cycle();
		ctrl_valid = 1'b0;
		ctrl_last = 1'b0;
		ctrl_beat = '0;
		repeat (4) cycle();  // let the write land before the next phv
		if (mod == DEPARSER_MOD_ID)
			model_tbl[addr] = acts;
	endtask

	task automatic build_expected(test_t t, logic [PHV_W-1:0] p);
		table_entry_t  ent;
		depar_action_t a;
		win_data_t     win;
		axis_beat_t    e;
		int            nb;
		int            base;
		int            pos;
		exp_q.delete();
		if (t.discard)
			return;
		win = '0;
		win[AXIS_DATA_W-1:0] = in_beats[0].tdata;
		if (t.len > 1)
			win[2*AXIS_DATA_W-1:AXIS_DATA_W] = in_beats[1].tdata;
		ent = model_tbl[t.vlan[8:4]];
		for (int i = 0; i < N_ACTIONS; i++) begin
			a = ent[i];
			case (a.ctype)
				B2: begin nb = 2; base = C2_BASE; end
				B4: begin nb = 4; base = C4_BASE; end
				B6: begin nb = 6; base = C6_BASE; end
				default: begin nb = 0; base = 0; end
			endcase
			if (a.valid) begin
				for (int b = 0; b < nb; b++) begin
					pos = int'(a.offset) + b;
					// msb of the container first
					if (pos < WIN_BYTES)
						win[pos*8 +: 8] = p[base + int'(a.idx)*nb*8 + (nb-1-b)*8 +: 8];
				end
			end
		end
		for (int k = 0; k < t.len; k++) begin
			e = in_beats[k];
			if (k == 0) begin
				e.tdata = win[AXIS_DATA_W-1:0];
				e.tuser = p[PHV_USER_LSB +: AXIS_USER_W];
			end else if (k == 1) begin
				e.tdata = win[2*AXIS_DATA_W-1:AXIS_DATA_W];
			end
			exp_q.push_back(e);
		end
	endtask

	task automatic check_beat(string name, int idx, axis_beat_t exp_b, axis_beat_t act_b);
		if (act_b !== exp_b) begin
			$display("ERROR %s beat %0d: expected %h actual %h", name, idx, exp_b, act_b);
			test_errs++;
		end
	endtask

	task automatic check_count(string name, int exp_n, int act_n);
		if (act_n < exp_n) begin
			$display("test %s: %0d output beats missing", name, exp_n - act_n);
			test_errs++;
		end else if (act_n > exp_n) begin
			$display("test %s: %0d extra output beats", name, act_n - exp_n);
			test_errs++;
		end
	endtask

	task automatic run_test(int n);
		test_t            t;
		logic [PHV_W-1:0] p;
		logic [PHV_W-1:0] r;
		axis_beat_t       b;
		int               cycles;
		int               n_chk;
		t = tests[n];
		test_errs = 0;
		if (t.has_ctrl)
			send_ctrl(t.mod_id, t.addr, t.acts);
		p = rand_bits(PHV_W);
		p[PHV_DISCARD_BIT] = t.discard;
		p[PHV_VLAN_LSB +: 12] = t.vlan;
		in_beats.delete();
		for (int k = 0; k < t.len; k++) begin
			r = rand_bits(AXIS_DATA_W);
			b.tdata = r[AXIS_DATA_W-1:0];
			r = rand_bits(AXIS_USER_W);
			b.tuser = r[AXIS_USER_W-1:0];
			b.tkeep = '1;
			b.tlast = (k == t.len - 1);
			if (b.tlast) begin
				r = rand_bits(AXIS_KEEP_W);
				b.tkeep = r[AXIS_KEEP_W-1:0];
				b.tkeep[0] = 1'b1;
			end
			in_beats.push_back(b);
		end
		build_expected(t, p);
		got.delete();
		cur_bp = t.bp;
		foreach (in_beats[k])
			pkt_q.push_back(in_beats[k]);
		phv_q.push_back(p);
		update_heads();
		cycles = 0;
		while ((pkt_q.size() != 0 || phv_q.size() != 0) && cycles < t.len * 20 + 50) begin
			cycle();
			cycles++;
		end
		if (pkt_q.size() != 0 || phv_q.size() != 0) begin
			$display("test %s: FIFOs still not drained after %0d cycles", t.name, cycles);
			test_errs++;
		end
		repeat (6) cycle();  // room for stray beats
		cur_bp = 1'b0;
		out_ready = 1'b1;
		check_count(t.name, t.exp_beats, got.size());
		n_chk = (got.size() < exp_q.size()) ? got.size() : exp_q.size();
		for (int k = 0; k < n_chk; k++)
			check_beat(t.name, k, exp_q[k], got[k]);
		if (test_errs == 0) begin
			pass_cnt++;
			$display("test %0d %s: ok", n, t.name);
		end else begin
			fail_cnt++;
			$display("test %0d %s: failed with %0d errors", n, t.name, test_errs);
		end
	endtask

	initial begin
		clk = 1'b0;
		aresetn = 1'b0;
		pkt_in = '0;
		pkt_empty = 1'b1;
		phv = '0;
		phv_empty = 1'b1;
		out_ready = 1'b1;
		ctrl_beat = '0;
		ctrl_last = 1'b0;
		ctrl_valid = 1'b0;
		cur_bp = 1'b0;
		pass_cnt = 0;
		fail_cnt = 0;
		load_tests();
		repeat (16) @(negedge clk);
		aresetn = 1'b1;
		repeat (2) @(negedge clk);
		for (int n = 0; n < NUM_TESTS; n++)
			run_test(n);
		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (fail_cnt == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// run limit from total packet length
	initial begin
		int limit;
		wait (aresetn === 1'b1);
		limit = 1000;
		for (int n = 0; n < NUM_TESTS; n++)
			limit += tests[n].len * 20;
		repeat (limit) @(posedge clk);
		$display("watchdog: run did not finish within %0d cycles", limit);
		$display("** FAIL **");
		$finish;
	end

endmodule

// ==== source/deparser_top.sv ====
`timescale 1ns/10ps

module deparser_top (
	input  logic                                clk,
	input  logic                                aresetn,

	input  depar_axis_pkg::axis_beat_t          pkt_in,
	input  logic                                pkt_empty,
	output logic                                pkt_rd_en,

	input  logic [depar_action_pkg::PHV_W-1:0]  phv,
	input  logic                                phv_empty,
	output logic                                phv_rd_en,

	output depar_axis_pkg::axis_beat_t          depar_out,
	output logic                                out_valid,
	input  logic                                out_ready,

	input  depar_action_pkg::ctrl_beat_u        ctrl_beat,
	input  logic                                ctrl_last,
	input  logic                                ctrl_valid
);
	import depar_axis_pkg::*;
	import depar_action_pkg::*;

	tbl_wr_t                 tbl_wr;
	table_entry_t            row;
	logic [TABLE_ADDR_W-1:0] rd_addr;
	logic                    extract;
	field_val_t              fields [N_ACTIONS];
	logic [N_ACTIONS-1:0]    ext_valid;
	logic                    field_valid;
	logic                    phv_discard;
	logic [AXIS_USER_W-1:0]  phv_user;

	assign rd_addr = phv[PHV_VLAN_LSB+4 +: TABLE_ADDR_W];  // vlan id bits 8:4
	assign phv_discard = phv[PHV_DISCARD_BIT];
	assign phv_user = phv[PHV_USER_LSB +: AXIS_USER_W];
	assign field_valid = &ext_valid;

	ctrl_table_writer u_ctrl (
		.clk        (clk),
		.aresetn    (aresetn),
		.ctrl_beat  (ctrl_beat),
		.ctrl_last  (ctrl_last),
		.ctrl_valid (ctrl_valid),
		.tbl_wr     (tbl_wr)
	);

	action_table u_table (
		.clk     (clk),
		.tbl_wr  (tbl_wr),
		.rd_addr (rd_addr),
		.row     (row)
	);

	for (genvar i = 0; i < N_ACTIONS; i++) begin : g_ext
		field_extractor u_ext (
			.clk     (clk),
			.aresetn (aresetn),
			.extract (extract),
			.action  (row[i]),
			.phv     (phv),
			.field   (fields[i]),
			.valid   (ext_valid[i])
		);
	end

	pkt_rewriter u_rewriter (
		.clk         (clk),
		.aresetn     (aresetn),
		.pkt_in      (pkt_in),
		.pkt_empty   (pkt_empty),
		.pkt_rd_en   (pkt_rd_en),
		.phv_discard (phv_discard),
		.phv_user    (phv_user),
		.phv_empty   (phv_empty),
		.phv_rd_en   (phv_rd_en),
		.row         (row),
		.extract     (extract),
		.fields      (fields),
		.field_valid (field_valid),
		.depar_out   (depar_out),
		.out_valid   (out_valid),
		.out_ready   (out_ready)
	);

endmodule

// ==== source/pkt_rewriter.sv ====
`timescale 1ns/10ps

module pkt_rewriter (
	input  logic                                      clk,
	input  logic                                      aresetn,

	input  depar_axis_pkg::axis_beat_t                pkt_in,
	input  logic                                      pkt_empty,
	output logic                                      pkt_rd_en,

	input  logic                                      phv_discard,
	input  logic [depar_axis_pkg::AXIS_USER_W-1:0]    phv_user,
	input  logic                                      phv_empty,
	output logic                                      phv_rd_en,

	input  depar_action_pkg::table_entry_t            row,
	output logic                                      extract,
	input  depar_action_pkg::field_val_t              fields [depar_action_pkg::N_ACTIONS],
	input  logic                                      field_valid,

	output depar_axis_pkg::axis_beat_t                depar_out,
	output logic                                      out_valid,
	input  logic                                      out_ready
);
	import depar_axis_pkg::*;
	import depar_action_pkg::*;

	typedef enum logic [3:0] {
		IDLE,
		CAP1,
		EXTRACT,
		WAIT,
		WRITEBACK,
		FLUSH0,
		FLUSH1,
		TAIL,
		DROP
	} rw_state_t;

	rw_state_t  state, state_next;
	axis_beat_t win [WIN_BEATS];
	win_data_t  wb_data;
	logic       start;

	function automatic int field_len(cont_type_t t);
		case (t)
			B2: return 2;
			B4: return 4;
			B6: return 6;
			default: return 0;
		endcase
	endfunction

	assign start = !pkt_empty && !phv_empty;

	// one pass over the actions, later ones overwrite earlier ones
	always_comb begin
		int len;
		wb_data = {win[1].tdata, win[0].tdata};
		for (int i = 0; i < N_ACTIONS; i++) begin
			len = field_len(fields[i].ctype);
			if (row[i].valid) begin
				for (int b = 0; b < 6; b++) begin
					if (b < len)
						wb_data[(row[i].offset + b)*8 +: 8] = fields[i].val[(6 - len + b)*8 +: 8];
				end
			end
		end
	end

	always_comb begin
		state_next = state;
		pkt_rd_en = 1'b0;
		phv_rd_en = 1'b0;
		extract = 1'b0;
		out_valid = 1'b0;
		depar_out = pkt_in;
		case (state)
			IDLE: begin
				if (start) begin
					pkt_rd_en = 1'b1;
					if (phv_discard) begin
						phv_rd_en = 1'b1;
						state_next = pkt_in.tlast ? IDLE : DROP;
					end else begin
						state_next = pkt_in.tlast ? EXTRACT : CAP1;
					end
				end
			end
			CAP1: begin
				if (!pkt_empty) begin
					pkt_rd_en = 1'b1;
					state_next = EXTRACT;
				end
			end
			EXTRACT: begin
				extract = 1'b1;
				state_next = WAIT;
			end
			WAIT: state_next = WRITEBACK;  // extractor registers settle
			WRITEBACK: state_next = FLUSH0;
			FLUSH0: begin
				depar_out = win[0];
				out_valid = 1'b1;
				if (out_ready) begin
					phv_rd_en = win[0].tlast;
					state_next = win[0].tlast ? IDLE : FLUSH1;
				end
			end
			FLUSH1: begin
				depar_out = win[1];
				out_valid = 1'b1;
				if (out_ready) begin
					phv_rd_en = 1'b1;
					state_next = win[1].tlast ? IDLE : TAIL;
				end
			end
			TAIL: begin
				out_valid = !pkt_empty;
				if (!pkt_empty && out_ready) begin
					pkt_rd_en = 1'b1;
					if (pkt_in.tlast)
						state_next = IDLE;
				end
			end
			DROP: begin
				if (!pkt_empty) begin
					pkt_rd_en = 1'b1;
					if (pkt_in.tlast)
						state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			state <= IDLE;
		else
			state <= state_next;
	end

	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (start) begin
					win[0] <= pkt_in;
					win[0].tuser <= phv_user;  // first beat carries the phv metadata
				end
			end
			CAP1: begin
				if (!pkt_empty)
					win[1] <= pkt_in;
			end
			WRITEBACK: begin
				win[0].tdata <= wb_data[0 +: AXIS_DATA_W];
				win[1].tdata <= wb_data[AXIS_DATA_W +: AXIS_DATA_W];
			end
			default: ;
		endcase
	end

	for (genvar i = 0; i < N_ACTIONS; i++) begin : g_chk
		a_in_window: assert property (@(posedge clk) disable iff (!aresetn)
			(state == WRITEBACK && row[i].valid) |->
			(int'(row[i].offset) + field_len(fields[i].ctype) <= WIN_BYTES));
	end

	a_field_timing: assert property (@(posedge clk) disable iff (!aresetn)
		field_valid |-> state == WAIT);

endmodule

// ==== source/ctrl_table_writer.sv ====
`timescale 1ns/10ps

module ctrl_table_writer (
	input  logic                          clk,
	input  logic                          aresetn,
	input  depar_action_pkg::ctrl_beat_u  ctrl_beat,
	input  logic                          ctrl_last,
	input  logic                          ctrl_valid,
	output depar_action_pkg::tbl_wr_t     tbl_wr
);
	import depar_action_pkg::*;

	typedef enum logic [2:0] {
		C_FIRST,
		C_HDR,
		C_ENTRY,
		C_COMMIT,
		C_SKIP
	} ctrl_state_t;

	ctrl_state_t             state, state_next;
	logic [31:0][7:0]        rev_lanes;
	logic [TABLE_ADDR_W-1:0] addr_r, addr_next;
	table_entry_t            entry_r, entry_next;
	logic                    en_r, en_next;

	// control data arrives with its first byte in the top lane
	always_comb begin
		for (int i = 0; i < 32; i++) begin
			rev_lanes[i] = ctrl_beat.lanes[31-i];
		end
	end

	always_comb begin
		state_next = state;
		addr_next = addr_r;
		entry_next = entry_r;
		en_next = 1'b0;
		if (ctrl_valid) begin
			case (state)
				C_FIRST: begin
					if (!ctrl_last)
						state_next = C_HDR;
				end
				C_HDR: begin
					if (ctrl_beat.hdr.mod_id[2:0] == DEPARSER_MOD_ID && !ctrl_last) begin
						addr_next = ctrl_beat.hdr.tbl_addr[TABLE_ADDR_W-1:0];
						state_next = C_ENTRY;
					end else begin
						state_next = ctrl_last ? C_FIRST : C_SKIP;  // not for us
					end
				end
				C_ENTRY: begin
					entry_next = rev_lanes[31:22];  // top 80 bits
					state_next = ctrl_last ? C_FIRST : C_COMMIT;
				end
				C_COMMIT: begin
					en_next = 1'b1;
					state_next = ctrl_last ? C_FIRST : C_SKIP;
				end
				default: begin
					if (ctrl_last)
						state_next = C_FIRST;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn) begin
			state <= C_FIRST;
			en_r <= 1'b0;
		end else begin
			state <= state_next;
			en_r <= en_next;
		end
	end

	always_ff @(posedge clk) begin
		addr_r <= addr_next;
		entry_r <= entry_next;
	end

	assign tbl_wr.en = en_r;
	assign tbl_wr.addr = addr_r;
	assign tbl_wr.entry = entry_r;

	a_single_write: assert property (@(posedge clk) disable iff (!aresetn)
		tbl_wr.en |=> !tbl_wr.en);

endmodule

// ==== source/field_extractor.sv ====
`timescale 1ns/10ps

module field_extractor (
	input  logic                                clk,
	input  logic                                aresetn,
	input  logic                                extract,
	input  depar_action_pkg::depar_action_t     action,
	input  logic [depar_action_pkg::PHV_W-1:0]  phv,
	output depar_action_pkg::field_val_t        field,
	output logic                                valid
);
	import depar_action_pkg::*;

	logic [47:0] raw;
	logic [47:0] swapped;

	// container right aligned in raw
	always_comb begin
		raw = '0;
		case (action.ctype)
			B2: raw[15:0] = phv[C2_BASE + 16*action.idx +: 16];
			B4: raw[31:0] = phv[C4_BASE + 32*action.idx +: 32];
			B6: raw = phv[C6_BASE + 48*action.idx +: 48];
			default: raw = '0;
		endcase
	end

	// full 6-byte swap also left justifies the short containers
	always_comb begin
		for (int b = 0; b < 6; b++) begin
			swapped[b*8 +: 8] = raw[(5-b)*8 +: 8];
		end
	end

	always_ff @(posedge clk) begin
		if (extract) begin
			field.ctype <= action.ctype;
			field.val <= swapped;
		end
	end

	always_ff @(posedge clk) begin
		if (!aresetn)
			valid <= 1'b0;
		else
			valid <= extract;
	end

	a_typed_action: assert property (@(posedge clk) disable iff (!aresetn)
		(extract && action.valid) |-> action.ctype != NONE);

endmodule

// ==== source/action_table.sv ====
`timescale 1ns/10ps

module action_table (
	input  logic                                       clk,
	input  depar_action_pkg::tbl_wr_t                  tbl_wr,
	input  logic [depar_action_pkg::TABLE_ADDR_W-1:0]  rd_addr,
	output depar_action_pkg::table_entry_t             row
);
	import depar_action_pkg::*;

	table_entry_t mem [TABLE_DEPTH];

	always_ff @(posedge clk) begin
		if (tbl_wr.en)
			mem[tbl_wr.addr] <= tbl_wr.entry;
	end

	// registered read, follows the phv head one cycle late
	always_ff @(posedge clk) begin
		row <= mem[rd_addr];
	end

endmodule

// ==== source/depar_action_pkg.sv ====
package depar_action_pkg;

	localparam int PHV_W = 1024;
	localparam int N_ACTIONS = 5;
	localparam int TABLE_DEPTH = 32;
	localparam int TABLE_ADDR_W = 5;

	// fixed fields of the phv
	localparam int PHV_USER_LSB = 0;
	localparam int PHV_DISCARD_BIT = 128;
	localparam int PHV_VLAN_LSB = 129;

	// eight containers of each size
	localparam int C2_BASE = 256;
	localparam int C4_BASE = 384;
	localparam int C6_BASE = 640;

	localparam logic [2:0] DEPARSER_MOD_ID = 3'd5;

	typedef enum logic [1:0] {
		NONE = 2'b00,
		B2   = 2'b01,
		B4   = 2'b10,
		B6   = 2'b11
	} cont_type_t;

	typedef struct packed {
		logic [3:0] rsvd;
		logic [5:0] offset;  // window byte offset
		cont_type_t ctype;
		logic [2:0] idx;     // container index
		logic       valid;
	} depar_action_t;

	// element 0 is the top 16 bits
	typedef depar_action_t [0:N_ACTIONS-1] table_entry_t;

	typedef struct packed {
		cont_type_t  ctype;
		logic [47:0] val;  // byte swapped, left justified
	} field_val_t;

	typedef struct packed {
		logic [119:0] rsvd_hi;
		logic [7:0]   tbl_addr;
		logic [7:0]   rsvd_mid;
		logic [7:0]   mod_id;
		logic [111:0] rsvd_lo;
	} ctrl_hdr_t;

	typedef union packed {
		ctrl_hdr_t        hdr;
		logic [31:0][7:0] lanes;
	} ctrl_beat_u;

	typedef struct packed {
		logic                    en;
		logic [TABLE_ADDR_W-1:0] addr;
		table_entry_t            entry;
	} tbl_wr_t;

endpackage

// ==== source/depar_axis_pkg.sv ====
package depar_axis_pkg;

	localparam int AXIS_DATA_W = 256;
	localparam int AXIS_KEEP_W = AXIS_DATA_W / 8;
	localparam int AXIS_USER_W = 128;

	// rewrite window covers the first two beats
	localparam int WIN_BEATS = 2;
	localparam int WIN_BYTES = WIN_BEATS * AXIS_KEEP_W;

	typedef struct packed {
		logic [AXIS_DATA_W-1:0] tdata;
		logic [AXIS_KEEP_W-1:0] tkeep;
		logic [AXIS_USER_W-1:0] tuser;
		logic                   tlast;
	} axis_beat_t;

	// byte k of the window sits at bits 8k+7:8k, beat 0 in the low half
	typedef logic [WIN_BYTES*8-1:0] win_data_t;

endpackage
